// File: filelist.f
groovy_pkg.sv
hps_cmd_decode.sv
hps_cmd_execute.sv
hps_status_readback.sv
hps_ext.sv
tb_hps_ext.sv

// File: groovy_pkg.sv
// shared definitions for the host command port
// bus word widths and the opcode enum with its range limits
// bus event, video and vram status, host config and av mode structs

package groovy_pkg;

    // one bus word and the word counter inside a transaction
    localparam int WORD_W  = 16;
    localparam int INDEX_W = 5;

    // host opcodes, sent as word 0 of a transaction
    typedef enum logic [15:0]
    {
        GET_GROOVY_STATUS = 16'h00F0,
        GET_GROOVY_HPS    = 16'h00F1,
        SET_INIT          = 16'h00F2,
        SET_SWITCHRES     = 16'h00F3,
        SET_BLIT          = 16'h00F4,
        SET_LOGO          = 16'h00F5,
        SET_AUDIO         = 16'h00F6
    } ext_cmd_e;

    // opcode window that the core answers
    localparam ext_cmd_e CMD_MIN = GET_GROOVY_STATUS;
    localparam ext_cmd_e CMD_MAX = SET_AUDIO;

    // one bus event as seen by execute and readback
    typedef struct packed
    {
        logic               strobe;
        // word number, saturates at the top
        logic [INDEX_W-1:0] index;
        // opcode of the running transaction, raw value
        logic [WORD_W-1:0]  cmd;
        logic [WORD_W-1:0]  data;
    } bus_word_t;

    // video timing state from the scan-out side
    typedef struct packed
    {
        logic [31:0] frame;
        logic [15:0] vcount;
        logic        vblank;
        logic        f1;
        logic        frameskip;
    } video_status_t;

    // vram fill state
    typedef struct packed
    {
        logic [23:0] pixels;
        logic [23:0] queue;
        logic        synced;
        logic        end_frame;
        logic        ready;
    } vram_status_t;

    // host settings, packed so the struct is the reply word
    // verbose sits in bits 1:0, arm_clock on top
    typedef struct packed
    {
        logic [1:0] arm_clock;
        logic       server_type;
        logic       jumbo_frames;
        logic [1:0] joy_inputs;
        logic [1:0] kbd_inputs;
        logic       screensaver;
        logic       blit;
        logic [1:0] verbose;
    } hps_config_t;

    // audio and rgb modes set by SET_INIT
    typedef struct packed
    {
        logic [1:0] sound_rate;
        logic [1:0] sound_chan;
        logic [1:0] rgb_mode;
    } av_mode_t;

endpackage

// File: hps_cmd_decode.sv
// transaction tracking for the host word bus
// latches the opcode, counts words and checks the opcode range

`timescale 1ns/1ps

module hps_cmd_decode
(
    input  logic                  clk_sys,
    input  logic                  reset_audio,
    input  logic                  io_enable,
    input  logic                  io_strobe,
    input  logic [15:0]           io_din,
    output groovy_pkg::bus_word_t word,
    output logic                  cmd_known,
    output logic                  dout_en
);

    // latched opcode and word counter of the current transaction
    logic [groovy_pkg::WORD_W-1:0]  cmd_q;
    logic [groovy_pkg::INDEX_W-1:0] index_q;
    logic                           dout_en_q;

    // strobes outside a transaction are ignored
    logic strobe;

    assign strobe = io_strobe && io_enable;

    // word 0 carries the opcode straight from the bus
    always_comb
    begin
        word.strobe = strobe;
        word.index  = index_q;
        word.cmd    = (index_q == '0) ? io_din : cmd_q;
        word.data   = io_din;
    end

    assign cmd_known = (word.cmd >= groovy_pkg::CMD_MIN) && (word.cmd <= groovy_pkg::CMD_MAX);
    assign dout_en   = dout_en_q;

    always_ff @(posedge clk_sys)
    begin
        if (reset_audio || !io_enable)
        begin
            cmd_q     <= '0;
            index_q   <= '0;
            dout_en_q <= 1'b0;
        end
        else if (strobe)
        begin
            // index holds at its maximum on long transactions
            if (index_q != '1)
            begin
                index_q <= index_q + 1'b1;
            end
            if (index_q == '0)
            begin
                cmd_q     <= io_din;
                dout_en_q <= cmd_known;
            end
        end
    end

    // the word index only moves on a strobe inside an enabled transaction
    a_index_step: assert property (@(posedge clk_sys) disable iff (reset_audio)
        (index_q != $past(index_q)) && (index_q != '0) |-> $past(io_enable && io_strobe));

endmodule

// File: hps_cmd_execute.sv
// write side of the host command port
// mode register, request flags with acknowledges, frame and sample count

`timescale 1ns/1ps

module hps_cmd_execute
(
    input  logic                  clk_sys,
    input  logic                  reset_audio,
    input  groovy_pkg::bus_word_t word,
    input  logic                  cmd_known,
    input  logic                  reset_switchres,
    input  logic                  reset_blit,
    output groovy_pkg::av_mode_t  av_mode,
    output logic                  cmd_init,
    output logic                  cmd_switchres,
    output logic                  cmd_blit,
    output logic                  cmd_logo,
    output logic                  cmd_audio,
    output logic [31:0]           switchres_frame,
    output logic [15:0]           audio_samples
);

    // init flag from word 1 waits for the mode word
    logic init_pending;

    // only strobes of a known opcode write anything
    logic wr;

    assign wr = word.strobe && cmd_known;

    always_ff @(posedge clk_sys)
    begin
        if (reset_audio)
        begin
            av_mode         <= '0;
            cmd_init        <= 1'b0;
            cmd_switchres   <= 1'b0;
            cmd_blit        <= 1'b0;
            cmd_logo        <= 1'b0;
            cmd_audio       <= 1'b0;
            switchres_frame <= '0;
            audio_samples   <= '0;
        end
        else
        begin
            // acknowledges first, a set below takes priority
            if (reset_switchres)
            begin
                cmd_switchres <= 1'b0;
            end
            if (reset_blit)
            begin
                cmd_blit <= 1'b0;
            end

            if (wr && (word.index == 5'd1))
            begin
                case (groovy_pkg::ext_cmd_e'(word.cmd))
                    groovy_pkg::SET_INIT:
                    begin
                        cmd_switchres <= 1'b0;
                        cmd_blit      <= 1'b0;
                        cmd_logo      <= 1'b0;
                        cmd_audio     <= 1'b0;
                        av_mode       <= '0;
                    end
                    groovy_pkg::SET_SWITCHRES: switchres_frame[15:0] <= word.data;
                    groovy_pkg::SET_BLIT:      cmd_blit <= word.data[0];
                    groovy_pkg::SET_LOGO:      cmd_logo <= word.data[0];
                    groovy_pkg::SET_AUDIO:
                    begin
                        audio_samples <= word.data;
                        cmd_audio     <= 1'b1;
                    end
                    default: ;
                endcase
            end

            if (wr && (word.index == 5'd2))
            begin
                case (groovy_pkg::ext_cmd_e'(word.cmd))
                    groovy_pkg::SET_INIT:
                    begin
                        av_mode.sound_rate <= word.data[1:0];
                        av_mode.sound_chan <= word.data[3:2];
                        av_mode.rgb_mode   <= word.data[5:4];
                        cmd_init           <= init_pending;
                    end
                    groovy_pkg::SET_SWITCHRES:
                    begin
                        switchres_frame[31:16] <= word.data;
                        cmd_switchres          <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // payload only, read at word 2
    always_ff @(posedge clk_sys)
    begin
        if (wr && (word.index == 5'd1) && (word.cmd == groovy_pkg::SET_INIT))
        begin
            init_pending <= word.data[0];
        end
    end

    // switchres request only comes from the high frame word
    a_switchres_src: assert property (@(posedge clk_sys) disable iff (reset_audio)
        $rose(cmd_switchres) |-> $past(wr && (word.index == 5'd2)
            && (word.cmd == groovy_pkg::SET_SWITCHRES)));

endmodule

// File: hps_ext.sv
// host command port top level
// decode feeds the bus word to the execute and readback blocks

`timescale 1ns/1ps

module hps_ext
#(
    parameter int RISE_CNT_W = 8
)
(
    input  logic                      clk_sys,
    input  logic                      reset_audio,
    input  logic                      io_enable,
    input  logic                      io_strobe,
    input  logic [15:0]               io_din,
    output logic [15:0]               io_dout,
    output logic                      dout_en,
    input  logic [7:0]                state,
    input  logic                      hps_rise,
    input  logic                      hps_audio,
    input  groovy_pkg::hps_config_t   hps_config,
    input  groovy_pkg::video_status_t video,
    input  groovy_pkg::vram_status_t  vram,
    input  logic                      reset_switchres,
    input  logic                      reset_blit,
    output groovy_pkg::av_mode_t      av_mode,
    output logic                      cmd_init,
    output logic                      cmd_switchres,
    output logic                      cmd_blit,
    output logic                      cmd_logo,
    output logic                      cmd_audio,
    output logic [31:0]               switchres_frame,
    output logic [15:0]               audio_samples
);

    // current bus event and its opcode check
    groovy_pkg::bus_word_t word;
    logic                  cmd_known;

    hps_cmd_decode u_decode
    (
        .clk_sys     (clk_sys),
        .reset_audio (reset_audio),
        .io_enable   (io_enable),
        .io_strobe   (io_strobe),
        .io_din      (io_din),
        .word        (word),
        .cmd_known   (cmd_known),
        .dout_en     (dout_en)
    );

    hps_cmd_execute u_execute
    (
        .clk_sys         (clk_sys),
        .reset_audio     (reset_audio),
        .word            (word),
        .cmd_known       (cmd_known),
        .reset_switchres (reset_switchres),
        .reset_blit      (reset_blit),
        .av_mode         (av_mode),
        .cmd_init        (cmd_init),
        .cmd_switchres   (cmd_switchres),
        .cmd_blit        (cmd_blit),
        .cmd_logo        (cmd_logo),
        .cmd_audio       (cmd_audio),
        .switchres_frame (switchres_frame),
        .audio_samples   (audio_samples)
    );

    hps_status_readback #(.RISE_CNT_W(RISE_CNT_W)) u_readback
    (
        .clk_sys     (clk_sys),
        .reset_audio (reset_audio),
        .word        (word),
        .cmd_known   (cmd_known),
        .io_enable   (io_enable),
        .hps_rise    (hps_rise),
        .state       (state),
        .hps_audio   (hps_audio),
        .hps_config  (hps_config),
        .video       (video),
        .vram        (vram),
        .io_dout     (io_dout)
    );

endmodule

// File: hps_status_readback.sv
// read side of the host command port
// hps_rise toggle counter, status snapshot and reply word mux

`timescale 1ns/1ps

module hps_status_readback
#(
    parameter int RISE_CNT_W = 8
)
(
    input  logic                      clk_sys,
    input  logic                      reset_audio,
    input  groovy_pkg::bus_word_t     word,
    input  logic                      cmd_known,
    input  logic                      io_enable,
    input  logic                      hps_rise,
    input  logic [7:0]                state,
    input  logic                      hps_audio,
    input  groovy_pkg::hps_config_t   hps_config,
    input  groovy_pkg::video_status_t video,
    input  groovy_pkg::vram_status_t  vram,
    output logic [15:0]               io_dout
);

    // edge detect on hps_rise, both edges count
    logic                  rise_d;
    logic [RISE_CNT_W-1:0] rise_cnt;

    // status frozen at word 1 of GET_GROOVY_STATUS
    groovy_pkg::video_status_t video_snap;
    groovy_pkg::vram_status_t  vram_snap;

    logic        snap_take;
    logic [15:0] reply;

    assign snap_take = word.strobe && cmd_known && (word.index == 5'd1)
        && (word.cmd == groovy_pkg::GET_GROOVY_STATUS);

    always_ff @(posedge clk_sys)
    begin
        if (reset_audio)
        begin
            rise_d   <= 1'b0;
            rise_cnt <= '0;
        end
        else
        begin
            rise_d <= hps_rise;
            // counter wraps freely
            if (rise_d ^ hps_rise)
            begin
                rise_cnt <= rise_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (snap_take)
        begin
            video_snap <= video;
            vram_snap  <= vram;
        end
    end

    // reply for the word on the bus this cycle
    always_comb
    begin
        reply = '0;
        if (word.index == '0)
        begin
            // unknown opcodes get a zero reply
            if (cmd_known)
            begin
                reply = 16'(rise_cnt);
            end
        end
        else if (cmd_known)
        begin
            case (groovy_pkg::ext_cmd_e'(word.cmd))
                groovy_pkg::GET_GROOVY_STATUS:
                    case (word.index)
                        // word 1 replies from the live frame counter
                        5'd1: reply = video.frame[15:0];
                        5'd2: reply = video_snap.frame[31:16];
                        5'd3: reply = video_snap.vcount;
                        5'd4: reply = {vram_snap.queue[7:0], |state, hps_audio,
                                       video_snap.f1, video_snap.vblank,
                                       video_snap.frameskip, vram_snap.synced,
                                       vram_snap.end_frame, vram_snap.ready};
                        5'd5: reply = vram_snap.queue[23:8];
                        5'd6: reply = vram_snap.pixels[15:0];
                        5'd7: reply = {8'd0, vram_snap.pixels[23:16]};
                        default: reply = '0;
                    endcase
                groovy_pkg::GET_GROOVY_HPS:
                    if (word.index == 5'd1)
                    begin
                        reply = 16'(hps_config);
                    end
                default: reply = '0;
            endcase
        end
    end

    // reply holds until the next strobe
    always_ff @(posedge clk_sys)
    begin
        if (reset_audio || !io_enable)
        begin
            io_dout <= '0;
        end
        else if (word.strobe)
        begin
            io_dout <= reply;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_hps_ext -f filelist.f -o sim_hps_ext
./obj_dir/sim_hps_ext | tee sim.log

if grep -q 'All tests passed!' sim.log; then
    exit 0
else
    exit 1
fi

// File: tb_hps_ext.sv
// testbench for the host command port
// clock and reset, LFSR stimulus, bus transaction tasks
// reference reply function, compare task and watchdog

`timescale 1ns/1ps

module tb_hps_ext;

    // transaction count sets the watchdog budget
    localparam int NUM_TXN = 12;

    logic                      clk_sys;
    logic                      reset_audio;
    logic                      io_enable;
    logic                      io_strobe;
    logic [15:0]               io_din;
    logic [15:0]               io_dout;
    logic                      dout_en;
    logic [7:0]                state;
    logic                      hps_rise;
    logic                      hps_audio;
    groovy_pkg::hps_config_t   hps_config;
    groovy_pkg::video_status_t video;
    groovy_pkg::vram_status_t  vram;
    logic                      reset_switchres;
    logic                      reset_blit;
    groovy_pkg::av_mode_t      av_mode;
    logic                      cmd_init;
    logic                      cmd_switchres;
    logic                      cmd_blit;
    logic                      cmd_logo;
    logic                      cmd_audio;
    logic [31:0]               switchres_frame;
    logic [15:0]               audio_samples;

    // model state: status copy frozen at word 1 and expected outputs
    groovy_pkg::video_status_t snap_video;
    groovy_pkg::vram_status_t  snap_vram;
    groovy_pkg::av_mode_t      m_av;
    logic                      m_init;
    logic                      m_sw;
    logic                      m_blit;
    logic                      m_logo;
    logic                      m_audio;
    logic [31:0]               m_frame;
    logic [15:0]               m_samples;
    int                        rise_count;
    int                        n_checks;
    int                        n_errors;
    logic [31:0]               lfsr_state = 32'h15e3_4f83;

    hps_ext #(.RISE_CNT_W(8)) u_dut
    (
        .clk_sys (clk_sys), .reset_audio (reset_audio), .io_enable (io_enable),
        .io_strobe (io_strobe), .io_din (io_din), .io_dout (io_dout), .dout_en (dout_en),
        .state (state), .hps_rise (hps_rise), .hps_audio (hps_audio),
        .hps_config (hps_config), .video (video), .vram (vram),
        .reset_switchres (reset_switchres), .reset_blit (reset_blit), .av_mode (av_mode),
        .cmd_init (cmd_init), .cmd_switchres (cmd_switchres), .cmd_blit (cmd_blit),
        .cmd_logo (cmd_logo), .cmd_audio (cmd_audio),
        .switchres_frame (switchres_frame), .audio_samples (audio_samples)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // galois shift, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v[i]        = lfsr_state[0];
            lfsr_state  = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic cmd_in_range(input logic [15:0] cmd);
        cmd_in_range = (cmd >= 16'h00F0) && (cmd <= 16'h00F6);
    endfunction

    // expected reply for word idx of opcode cmd
    function automatic logic [15:0] ref_reply(input logic [15:0] cmd, input int idx);
        ref_reply = 16'h0000;
        if (!cmd_in_range(cmd))
        begin
            ref_reply = 16'h0000;
        end
        else if (idx == 0)
        begin
            // toggle count, low byte only
            ref_reply = 16'(rise_count % 256);
        end
        else if (cmd == groovy_pkg::GET_GROOVY_STATUS)
        begin
            case (idx)
                1: ref_reply = snap_video.frame[15:0];
                2: ref_reply = snap_video.frame[31:16];
                3: ref_reply = snap_video.vcount;
                4: ref_reply = {snap_vram.queue[7:0], (state != 8'd0), hps_audio,
                                snap_video.f1, snap_video.vblank, snap_video.frameskip,
                                snap_vram.synced, snap_vram.end_frame, snap_vram.ready};
                5: ref_reply = snap_vram.queue[23:8];
                6: ref_reply = snap_vram.pixels[15:0];
                7: ref_reply = {8'h00, snap_vram.pixels[23:16]};
                default: ref_reply = 16'h0000;
            endcase
        end
        else if ((cmd == groovy_pkg::GET_GROOVY_HPS) && (idx == 1))
        begin
            ref_reply = {4'h0, hps_config};
        end
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // inputs move 1 ns after the rising edge
    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic check_outputs();
        compare("io_dout", 64'(io_dout), 64'(0));
        compare("dout_en", 64'(dout_en), 64'(0));
        compare("av_mode", 64'(av_mode), 64'(m_av));
        compare("cmd_init", 64'(cmd_init), 64'(m_init));
        compare("cmd_switchres", 64'(cmd_switchres), 64'(m_sw));
        compare("cmd_blit", 64'(cmd_blit), 64'(m_blit));
        compare("cmd_logo", 64'(cmd_logo), 64'(m_logo));
        compare("cmd_audio", 64'(cmd_audio), 64'(m_audio));
        compare("switchres_frame", 64'(switchres_frame), 64'(m_frame));
        compare("audio_samples", 64'(audio_samples), 64'(m_samples));
    endtask

    // hps_rise held low so the edge detect restarts clean
    task automatic apply_reset();
        reset_audio = 1'b1;
        hps_rise    = 1'b0;
        repeat (3) step();
        reset_audio = 1'b0;
        rise_count  = 0;
        m_av        = '0;
        {m_init, m_sw, m_blit, m_logo, m_audio} = '0;
        m_frame     = '0;
        m_samples   = '0;
    endtask

    task automatic toggle_rise(input int n);
        repeat (n)
        begin
            hps_rise = ~hps_rise;
            rise_count++;
            step();
        end
    endtask

    task automatic randomize_status();
        logic [63:0] r;
        take_bits(51, r);
        video = groovy_pkg::video_status_t'(r[50:0]);
        take_bits(51, r);
        vram  = groovy_pkg::vram_status_t'(r[50:0]);
    endtask

    // one strobe, reply read two edges later
    task automatic send_word(input logic [15:0] cmd, input int idx, input logic [15:0] data);
        io_din    = data;
        io_strobe = 1'b1;
        step();
        io_strobe = 1'b0;
        if ((idx == 1) && (cmd == groovy_pkg::GET_GROOVY_STATUS))
        begin
            snap_video = video;
            snap_vram  = vram;
        end
        step();
        compare("io_dout", 64'(io_dout), 64'(ref_reply(cmd, idx)));
        compare("dout_en", 64'(dout_en), 64'(cmd_in_range(cmd)));
    endtask

    task automatic run_cmd(input logic [15:0] cmd, input logic [15:0] w1,
                           input logic [15:0] w2, input int n_words);
        io_enable = 1'b1;
        step();
        send_word(cmd, 0, cmd);
        send_word(cmd, 1, w1);
        if (n_words > 2)
        begin
            send_word(cmd, 2, w2);
        end
        io_enable = 1'b0;
        io_din    = 16'h0000;
        step();
    endtask

    // watchdog, budget from the transaction count
    initial
    begin
        repeat ((NUM_TXN * 40) + 200) @(posedge clk_sys);
        $display("watchdog expired, the test sequence did not complete");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        logic [63:0] r;
        n_checks = 0;
        n_errors = 0;
        io_enable = 1'b0;
        io_strobe = 1'b0;
        io_din = 16'h0000;
        state = 8'h00;
        hps_rise = 1'b0;
        hps_audio = 1'b0;
        hps_config = '0;
        video = '0;
        vram = '0;
        reset_switchres = 1'b0;
        reset_blit = 1'b0;
        apply_reset();
        check_outputs();

        // status snapshot, inputs change after word 1
        randomize_status();
        take_bits(9, r);
        state = r[7:0];
        hps_audio = r[8];
        take_bits(3, r);
        toggle_rise(int'(r[2:0]) + 1);
        io_enable = 1'b1;
        step();
        send_word(groovy_pkg::GET_GROOVY_STATUS, 0, groovy_pkg::GET_GROOVY_STATUS);
        for (int i = 1; i < 8; i++)
        begin
            send_word(groovy_pkg::GET_GROOVY_STATUS, i, 16'h0000);
            if (i == 1)
            begin
                randomize_status();
            end
        end
        io_enable = 1'b0;
        step();
        check_outputs();

        take_bits(12, r);
        hps_config = groovy_pkg::hps_config_t'(r[11:0]);
        run_cmd(groovy_pkg::GET_GROOVY_HPS, 16'h0000, 16'h0000, 2);

        take_bits(32, r);
        run_cmd(groovy_pkg::SET_SWITCHRES, r[15:0], r[31:16], 3);
        m_frame = r[31:0];
        m_sw = 1'b1;
        take_bits(16, r);
        run_cmd(groovy_pkg::SET_AUDIO, r[15:0], 16'h0000, 2);
        m_samples = r[15:0];
        m_audio = 1'b1;
        take_bits(16, r);
        run_cmd(groovy_pkg::SET_BLIT, r[15:0] | 16'h0001, 16'h0000, 2);
        take_bits(16, r);
        run_cmd(groovy_pkg::SET_LOGO, r[15:0] | 16'h0001, 16'h0000, 2);
        {m_blit, m_logo} = 2'b11;
        check_outputs();

        // acknowledges clear only their own flag
        reset_switchres = 1'b1;
        step();
        reset_switchres = 1'b0;
        m_sw = 1'b0;
        check_outputs();
        reset_blit = 1'b1;
        step();
        reset_blit = 1'b0;
        m_blit = 1'b0;
        check_outputs();
        take_bits(16, r);
        run_cmd(groovy_pkg::SET_BLIT, r[15:0], 16'h0000, 2);
        m_blit = r[0];
        check_outputs();

        // init clears flags, modes from the second word
        // bit 0 of the first word raises cmd_init
        take_bits(32, r);
        run_cmd(groovy_pkg::SET_INIT, r[15:0] | 16'h0001, r[31:16], 3);
        {m_sw, m_blit, m_logo, m_audio} = '0;
        m_av.sound_rate = r[17:16];
        m_av.sound_chan = r[19:18];
        m_av.rgb_mode = r[21:20];
        m_init = 1'b1;
        check_outputs();

        // unknown opcode is ignored
        take_bits(32, r);
        run_cmd(16'h00F9, r[15:0], r[31:16], 3);
        check_outputs();

        take_bits(16, r);
        run_cmd(groovy_pkg::SET_AUDIO, r[15:0], 16'h0000, 2);
        m_samples = r[15:0];
        m_audio = 1'b1;
        check_outputs();
        apply_reset();
        check_outputs();
        take_bits(4, r);
        toggle_rise(int'(r[3:0]) + 1);
        run_cmd(groovy_pkg::GET_GROOVY_HPS, 16'h0000, 16'h0000, 2);
        check_outputs();

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
